// File: common/exec_pkg.sv
package exec_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Datapath widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int data_w     = 32;
  localparam int reg_addr_w = 3;
  localparam int num_regs   = 8;
  localparam int opcode_w   = 4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Micro-op opcodes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [opcode_w-1:0] op_add  = 4'd0;
  localparam logic [opcode_w-1:0] op_adc  = 4'd1;
  localparam logic [opcode_w-1:0] op_sub  = 4'd2;
  localparam logic [opcode_w-1:0] op_sbb  = 4'd3;
  localparam logic [opcode_w-1:0] op_and  = 4'd4;
  localparam logic [opcode_w-1:0] op_or   = 4'd5;
  localparam logic [opcode_w-1:0] op_xor  = 4'd6;
  localparam logic [opcode_w-1:0] op_mul  = 4'd7;
  localparam logic [opcode_w-1:0] op_div  = 4'd8;
  localparam logic [opcode_w-1:0] op_cmp  = 4'd9;
  localparam logic [opcode_w-1:0] op_test = 4'd10;
  localparam logic [opcode_w-1:0] op_ldi  = 4'd11;
  localparam logic [opcode_w-1:0] op_clc  = 4'd12;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ALU control word
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int cntl_w = 14;

  // One-hot operation select
  localparam int alu_op_add  = 0;
  localparam int alu_op_sub  = 1;
  localparam int alu_op_and  = 2;
  localparam int alu_op_or   = 3;
  localparam int alu_op_xor  = 4;
  localparam int alu_op_mul  = 5;
  localparam int alu_op_pass = 6;

  // Modifiers
  localparam int alu_use_carry  = 7;
  localparam int alu_no_wr      = 8;
  localparam int alu_clear_cf   = 9;
  localparam int alu_clear_of   = 10;
  localparam int alu_flags_keep = 11;
  // Bits 12 and 13 are spare

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Status flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int stat_w  = 5;
  localparam int stat_cf = 0;
  localparam int stat_pf = 1;
  localparam int stat_zf = 2;
  localparam int stat_sf = 3;
  localparam int stat_of = 4;

  // Iterative divider
  localparam int div_cycles = 32;
  localparam int div_cnt_w  = $clog2(div_cycles);

endpackage

// File: execute/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic [exec_pkg::cntl_w-1:0] cntl,
  input  logic [exec_pkg::stat_w-1:0] status_in,
  input  logic [exec_pkg::data_w-1:0] opnd0,
  input  logic [exec_pkg::data_w-1:0] opnd1,
  output logic [exec_pkg::stat_w-1:0] status_out,
  output logic [exec_pkg::data_w-1:0] result
);
  import exec_pkg::*;

  logic                carry;
  logic [data_w:0]     sum;
  logic [data_w:0]     diff;
  logic [2*data_w-1:0] product;
  logic [data_w-1:0]   op_result;
  logic                raw_cf;
  logic                raw_of;
  logic                keep;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Arithmetic and logic units
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Carry only enters for ADC and SBB
  assign carry = cntl[alu_use_carry] & status_in[stat_cf];

  // Bit data_w is carry out for add and borrow for sub
  assign sum  = {1'b0, opnd0} + {1'b0, opnd1} + {{data_w{1'b0}}, carry};
  assign diff = {1'b0, opnd0} - {1'b0, opnd1} - {{data_w{1'b0}}, carry};

  // Full width product so the high half can drive CF
  assign product = {{data_w{1'b0}}, opnd0} * {{data_w{1'b0}}, opnd1};

  // One-hot AND-OR select
  assign op_result = ({data_w{cntl[alu_op_add]}}  & sum[data_w-1:0])
                   | ({data_w{cntl[alu_op_sub]}}  & diff[data_w-1:0])
                   | ({data_w{cntl[alu_op_and]}}  & (opnd0 & opnd1))
                   | ({data_w{cntl[alu_op_or]}}   & (opnd0 | opnd1))
                   | ({data_w{cntl[alu_op_xor]}}  & (opnd0 ^ opnd1))
                   | ({data_w{cntl[alu_op_mul]}}  & product[data_w-1:0])
                   | ({data_w{cntl[alu_op_pass]}} & opnd1);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Logic ops and pass leave both raw flags low
  always_comb begin
    raw_cf = 1'b0;
    raw_of = 1'b0;
    if (cntl[alu_op_add]) begin
      raw_cf = sum[data_w];
      raw_of = (opnd0[data_w-1] == opnd1[data_w-1]) &&
               (sum[data_w-1] != opnd0[data_w-1]);
    end else if (cntl[alu_op_sub]) begin
      raw_cf = diff[data_w];
      raw_of = (opnd0[data_w-1] != opnd1[data_w-1]) &&
               (diff[data_w-1] != opnd0[data_w-1]);
    end else if (cntl[alu_op_mul]) begin
      raw_cf = |product[2*data_w-1:data_w];
      raw_of = |product[2*data_w-1:data_w];
    end
  end

  assign keep = cntl[alu_flags_keep];

  // Clear wins over keep, so CLC can drop CF and hold the rest
  assign status_out[stat_cf] = cntl[alu_clear_cf] ? 1'b0 :
                               keep               ? status_in[stat_cf] :
                                                    raw_cf;

  assign status_out[stat_of] = cntl[alu_clear_of] ? 1'b0 :
                               keep               ? status_in[stat_of] :
                                                    raw_of;

  // x86 parity over the low byte only
  assign status_out[stat_pf] = keep ? status_in[stat_pf] : ~^op_result[7:0];
  assign status_out[stat_zf] = keep ? status_in[stat_zf] : (op_result == '0);
  assign status_out[stat_sf] = keep ? status_in[stat_sf] : op_result[data_w-1];

  // CMP, TEST and CLC return zero
  assign result = cntl[alu_no_wr] ? '0 : op_result;

endmodule

// File: execute/divider.sv
`timescale 1ns/1ps

module divider (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic [exec_pkg::data_w-1:0] dividend,
  input  logic [exec_pkg::data_w-1:0] divisor,
  output logic                        done,
  output logic [exec_pkg::data_w-1:0] quotient,
  output logic                        div_by_zero
);
  import exec_pkg::*;

  logic                 running;
  logic [div_cnt_w-1:0] count;
  logic                 zero_r;
  logic [data_w-1:0]    rem_r;
  logic [data_w-1:0]    div_r;
  logic [data_w-1:0]    cur_rem;
  logic [data_w-1:0]    cur_quo;
  logic [data_w-1:0]    cur_div;
  logic [data_w:0]      shifted;
  logic [data_w:0]      trial;
  logic                 fits;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // One restoring step per clock
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // First step runs on the start edge straight from the inputs
  assign cur_rem = start ? '0 : rem_r;
  assign cur_quo = start ? dividend : quotient;
  assign cur_div = start ? divisor : div_r;

  // Remainder picks up the next dividend bit from the top of the quotient
  assign shifted = {cur_rem, cur_quo[data_w-1]};
  assign trial   = shifted - {1'b0, cur_div};
  assign fits    = ~trial[data_w];

  // A zero divisor always fits, so the quotient ends up all ones
  always_ff @(posedge clk) begin
    if (start || running) begin
      rem_r    <= fits ? trial[data_w-1:0] : shifted[data_w-1:0];
      quotient <= {cur_quo[data_w-2:0], fits};
    end
    if (start) begin
      div_r <= divisor;
    end
  end

  // Iteration count and completion
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running     <= 1'b0;
      count       <= '0;
      zero_r      <= 1'b0;
      done        <= 1'b0;
      div_by_zero <= 1'b0;
    end else begin
      done        <= 1'b0;
      div_by_zero <= 1'b0;
      if (start) begin
        running <= 1'b1;
        count   <= div_cnt_w'(1);
        zero_r  <= (divisor == '0);
      end else if (running) begin
        count <= count + 1'b1;
        // Last of div_cycles steps
        if (count == div_cnt_w'(div_cycles - 1)) begin
          running     <= 1'b0;
          done        <= 1'b1;
          div_by_zero <= zero_r;
        end
      end
    end
  end

endmodule

// File: execute/execute.sv
`timescale 1ns/1ps

module execute (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            issue,
  input  logic [exec_pkg::cntl_w-1:0]     cntl,
  input  logic                            is_div,
  input  logic                            no_wb,
  input  logic [exec_pkg::reg_addr_w-1:0] dst,
  input  logic [exec_pkg::data_w-1:0]     opnd0,
  input  logic [exec_pkg::data_w-1:0]     opnd1,
  input  logic                            use_imm,
  input  logic [exec_pkg::data_w-1:0]     imm,
  output logic                            busy,
  output logic                            done,
  output logic [exec_pkg::data_w-1:0]     wb_data,
  output logic [exec_pkg::stat_w-1:0]     flags,
  output logic                            div_zero,
  output logic                            rf_wr_en,
  output logic [exec_pkg::reg_addr_w-1:0] rf_wr_addr,
  output logic [exec_pkg::data_w-1:0]     rf_wr_data
);
  import exec_pkg::*;

  logic                  accept;
  logic                  div_start;
  logic [data_w-1:0]     src1;
  logic [cntl_w-1:0]     div_cntl_r;
  logic [reg_addr_w-1:0] div_dst_r;
  logic [cntl_w-1:0]     alu_cntl;
  logic [data_w-1:0]     alu_opnd1;
  logic [data_w-1:0]     alu_result;
  logic [stat_w-1:0]     alu_status;
  logic                  div_done;
  logic                  div_zero_w;
  logic [data_w-1:0]     quotient;

  // Issue is dropped while a divide is running
  assign accept    = issue & ~busy;
  assign div_start = accept & is_div;
  assign src1      = use_imm ? imm : opnd1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ALU input select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // On divide completion the ALU passes the quotient to derive the flags
  always_comb begin
    alu_cntl  = cntl;
    alu_opnd1 = src1;
    if (div_done) begin
      alu_cntl  = div_cntl_r;
      alu_opnd1 = quotient;
      // Zero divisor leaves every flag as it was
      if (div_zero_w) begin
        alu_cntl[alu_clear_cf]   = 1'b0;
        alu_cntl[alu_clear_of]   = 1'b0;
        alu_cntl[alu_flags_keep] = 1'b1;
      end
    end
  end

  alu alu_i (
    .cntl       (alu_cntl),
    .status_in  (flags),
    .opnd0      (opnd0),
    .opnd1      (alu_opnd1),
    .status_out (alu_status),
    .result     (alu_result)
  );

  divider divider_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (div_start),
    .dividend    (opnd0),
    .divisor     (src1),
    .done        (div_done),
    .quotient    (quotient),
    .div_by_zero (div_zero_w)
  );

  // Divide context held until the quotient returns
  always_ff @(posedge clk) begin
    if (div_start) begin
      div_cntl_r <= cntl;
      div_dst_r  <= dst;
    end
  end

  // Write port lands on the same edge as done
  assign rf_wr_en   = div_done | (accept & ~is_div & ~no_wb);
  assign rf_wr_addr = div_done ? div_dst_r : dst;
  assign rf_wr_data = alu_result;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Completion, flags and writeback
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      div_zero <= 1'b0;
      wb_data  <= '0;
      flags    <= '0;
    end else begin
      done     <= 1'b0;
      div_zero <= 1'b0;
      if (div_done) begin
        busy     <= 1'b0;
        done     <= 1'b1;
        div_zero <= div_zero_w;
        wb_data  <= alu_result;
        flags    <= alu_status;
      end else if (accept) begin
        if (is_div) begin
          busy <= 1'b1;
        end else begin
          done    <= 1'b1;
          wb_data <= alu_result;
          flags   <= alu_status;
        end
      end
    end
  end

endmodule

// File: verilog/uop_decode.sv
`timescale 1ns/1ps

module uop_decode (
  input  logic [exec_pkg::opcode_w-1:0] opcode,
  output logic [exec_pkg::cntl_w-1:0]   cntl,
  output logic                          is_div,
  output logic                          no_wb
);
  import exec_pkg::*;

  always_comb begin
    cntl   = '0;
    is_div = 1'b0;
    no_wb  = 1'b0;
    case (opcode)
      op_add: cntl[alu_op_add] = 1'b1;
      op_adc: begin
        cntl[alu_op_add]    = 1'b1;
        cntl[alu_use_carry] = 1'b1;
      end
      op_sub: cntl[alu_op_sub] = 1'b1;
      op_sbb: begin
        cntl[alu_op_sub]    = 1'b1;
        cntl[alu_use_carry] = 1'b1;
      end
      op_and: cntl[alu_op_and] = 1'b1;
      op_or:  cntl[alu_op_or]  = 1'b1;
      op_xor: cntl[alu_op_xor] = 1'b1;
      op_mul: cntl[alu_op_mul] = 1'b1;
      // Used when the quotient comes back
      op_div: begin
        is_div             = 1'b1;
        cntl[alu_op_pass]  = 1'b1;
        cntl[alu_clear_cf] = 1'b1;
        cntl[alu_clear_of] = 1'b1;
      end
      // Compares set flags only
      op_cmp: begin
        cntl[alu_op_sub] = 1'b1;
        cntl[alu_no_wr]  = 1'b1;
        no_wb            = 1'b1;
      end
      op_test: begin
        cntl[alu_op_and] = 1'b1;
        cntl[alu_no_wr]  = 1'b1;
        no_wb            = 1'b1;
      end
      op_ldi: begin
        cntl[alu_op_pass]    = 1'b1;
        cntl[alu_flags_keep] = 1'b1;
      end
      op_clc: begin
        cntl[alu_no_wr]      = 1'b1;
        cntl[alu_flags_keep] = 1'b1;
        cntl[alu_clear_cf]   = 1'b1;
        no_wb                = 1'b1;
      end
      // Unassigned opcodes complete as a no-op
      default: begin
        cntl[alu_no_wr]      = 1'b1;
        cntl[alu_flags_keep] = 1'b1;
        no_wb                = 1'b1;
      end
    endcase
  end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [exec_pkg::reg_addr_w-1:0] rd_addr0,
  input  logic [exec_pkg::reg_addr_w-1:0] rd_addr1,
  input  logic                            wr_en,
  input  logic [exec_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [exec_pkg::data_w-1:0]     wr_data,
  output logic [exec_pkg::data_w-1:0]     rd_data0,
  output logic [exec_pkg::data_w-1:0]     rd_data1
);
  import exec_pkg::*;

  logic [data_w-1:0] regs [num_regs];

  // Register 0 is an ordinary register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // No bypass, same-cycle reads see the old value
  assign rd_data0 = regs[rd_addr0];
  assign rd_data1 = regs[rd_addr1];

endmodule

// File: verilog/exec_core_top.sv
`timescale 1ns/1ps

module exec_core_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            issue,
  input  logic [exec_pkg::opcode_w-1:0]   opcode,
  input  logic [exec_pkg::reg_addr_w-1:0] dst,
  input  logic [exec_pkg::reg_addr_w-1:0] src0,
  input  logic [exec_pkg::reg_addr_w-1:0] src1,
  input  logic                            use_imm,
  input  logic [exec_pkg::data_w-1:0]     imm,
  output logic                            busy,
  output logic                            done,
  output logic [exec_pkg::data_w-1:0]     wb_data,
  output logic [exec_pkg::stat_w-1:0]     flags,
  output logic                            div_zero
);
  import exec_pkg::*;

  logic [cntl_w-1:0]     cntl;
  logic                  is_div;
  logic                  no_wb;
  logic [data_w-1:0]     rd_data0;
  logic [data_w-1:0]     rd_data1;
  logic                  rf_wr_en;
  logic [reg_addr_w-1:0] rf_wr_addr;
  logic [data_w-1:0]     rf_wr_data;

  uop_decode uop_decode_i (
    .opcode (opcode),
    .cntl   (cntl),
    .is_div (is_div),
    .no_wb  (no_wb)
  );

  reg_file reg_file_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_addr0 (src0),
    .rd_addr1 (src1),
    .wr_en    (rf_wr_en),
    .wr_addr  (rf_wr_addr),
    .wr_data  (rf_wr_data),
    .rd_data0 (rd_data0),
    .rd_data1 (rd_data1)
  );

  // Immediate select happens inside the execute stage
  execute execute_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue      (issue),
    .cntl       (cntl),
    .is_div     (is_div),
    .no_wb      (no_wb),
    .dst        (dst),
    .opnd0      (rd_data0),
    .opnd1      (rd_data1),
    .use_imm    (use_imm),
    .imm        (imm),
    .busy       (busy),
    .done       (done),
    .wb_data    (wb_data),
    .flags      (flags),
    .div_zero   (div_zero),
    .rf_wr_en   (rf_wr_en),
    .rf_wr_addr (rf_wr_addr),
    .rf_wr_data (rf_wr_data)
  );

endmodule

// File: testbench/tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core;
  import exec_pkg::*;

  // About twice the cycles of 300 micro-ops and 40 divides of 33 cycles each
  localparam int          max_cycles = 4000;
  localparam logic [31:0] lfsr_taps  = 32'h8020_0003;

  logic                  clk;
  logic                  rst_n;
  logic                  issue;
  logic [opcode_w-1:0]   opcode;
  logic [reg_addr_w-1:0] dst;
  logic [reg_addr_w-1:0] src0;
  logic [reg_addr_w-1:0] src1;
  logic                  use_imm;
  logic [data_w-1:0]     imm;
  logic                  busy;
  logic                  done;
  logic [data_w-1:0]     wb_data;
  logic [stat_w-1:0]     flags;
  logic                  div_zero;

  // Reference state
  logic [data_w-1:0] shadow_regs [num_regs];
  logic [stat_w-1:0] shadow_flags;
  logic [31:0]       lfsr_state;
  int                cycle_count;

  exec_core_top dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .issue    (issue),
    .opcode   (opcode),
    .dst      (dst),
    .src0     (src0),
    .src1     (src1),
    .use_imm  (use_imm),
    .imm      (imm),
    .busy     (busy),
    .done     (done),
    .wb_data  (wb_data),
    .flags    (flags),
    .div_zero (div_zero)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      abort_run("Timeout: the run did not finish within the cycle limit");
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else abort_run($sformatf("CHECK FAILED %s: expected 0x%08h actual 0x%08h",
                               name, expected, actual));
  endtask

  // Zero divisor is only reported with completion
  assert property (@(posedge clk) disable iff (!rst_n) div_zero |-> done)
    else abort_run("div_zero was high without done");
  // busy falls on the completing edge
  assert property (@(posedge clk) disable iff (!rst_n) done |-> !busy)
    else abort_run("done and busy were high together");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus source and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ lfsr_taps;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic low_byte_parity(input logic [7:0] b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      ones += int'(b[i]);
    end
    return (ones % 2) == 0;
  endfunction

  function automatic logic [stat_w-1:0] flags_for(input logic [31:0] v, input logic cf,
                                                  input logic ovf);
    logic [stat_w-1:0] f;
    f[stat_cf] = cf;
    f[stat_of] = ovf;
    f[stat_pf] = low_byte_parity(v[7:0]);
    f[stat_zf] = (v == 32'd0);
    f[stat_sf] = v[31];
    return f;
  endfunction

  task automatic model_alu(input logic [opcode_w-1:0] op, input logic [31:0] a,
                           input logic [31:0] b, output logic [31:0] wb, output logic wr);
    logic [63:0] wide;
    logic [31:0] v;
    logic        cin;
    logic        cf;
    logic        ovf;
    cin = (op == op_adc || op == op_sbb) ? shadow_flags[stat_cf] : 1'b0;
    v   = '0;
    cf  = 1'b0;
    ovf = 1'b0;
    wr  = 1'b1;
    case (op)
      op_add, op_adc: begin
        wide = 64'(a) + 64'(b) + 64'(cin);
        v    = wide[31:0];
        cf   = wide[32];
        ovf  = (a[31] == b[31]) && (v[31] != a[31]);
      end
      op_sub, op_sbb, op_cmp: begin
        v   = a - b - 32'(cin);
        cf  = 64'(a) < (64'(b) + 64'(cin));
        ovf = (a[31] != b[31]) && (v[31] != a[31]);
      end
      op_and, op_test: v = a & b;
      op_or:  v = a | b;
      op_xor: v = a ^ b;
      op_mul: begin
        wide = 64'(a) * 64'(b);
        v    = wide[31:0];
        cf   = (wide[63:32] != 32'd0);
        ovf  = cf;
      end
      default: ;
    endcase
    case (op)
      op_ldi: wb = b;
      op_clc: begin
        wb = '0;
        wr = 1'b0;
        shadow_flags[stat_cf] = 1'b0;
      end
      op_cmp, op_test: begin
        wb = '0;
        wr = 1'b0;
        shadow_flags = flags_for(v, cf, ovf);
      end
      default: begin
        wb = v;
        shadow_flags = flags_for(v, cf, ovf);
      end
    endcase
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Micro-op drivers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic run_uop(input string name, input logic [opcode_w-1:0] op,
                         input logic [reg_addr_w-1:0] d, s0, s1,
                         input logic ui, input logic [31:0] im);
    logic [31:0] exp_wb;
    logic        wr;
    model_alu(op, shadow_regs[s0], ui ? im : shadow_regs[s1], exp_wb, wr);
    opcode  = op;
    dst     = d;
    src0    = s0;
    src1    = s1;
    use_imm = ui;
    imm     = im;
    issue   = 1'b1;
    @(posedge clk);
    #1;
    issue = 1'b0;
    check_value({name, " done"}, 32'd1, 32'(done));
    check_value({name, " wb_data"}, exp_wb, wb_data);
    check_value({name, " flags"}, 32'(shadow_flags), 32'(flags));
    check_value({name, " div_zero"}, 32'd0, 32'(div_zero));
    if (wr) begin
      shadow_regs[d] = exp_wb;
    end
  endtask

  // With poke set, an LDI to the neighbouring register is pulsed mid-divide
  task automatic run_div(input string name, input logic [reg_addr_w-1:0] d, s0, s1,
                         input logic ui, input logic [31:0] im, input logic poke);
    logic [31:0]       b;
    logic [31:0]       exp_q;
    logic [stat_w-1:0] exp_flags;
    int                waited;
    b         = ui ? im : shadow_regs[s1];
    exp_flags = shadow_flags;
    exp_q     = 32'hffff_ffff;
    if (b != 32'd0) begin
      exp_q     = shadow_regs[s0] / b;
      exp_flags = flags_for(exp_q, 1'b0, 1'b0);
    end
    opcode  = op_div;
    dst     = d;
    src0    = s0;
    src1    = s1;
    use_imm = ui;
    imm     = im;
    issue   = 1'b1;
    @(posedge clk);
    #1;
    waited = 1;
    while (!done) begin
      check_value({name, " busy"}, 32'd1, 32'(busy));
      issue = 1'b0;
      if (poke && waited == 4) begin
        opcode  = op_ldi;
        dst     = d ^ 3'd1;
        use_imm = 1'b1;
        imm     = 32'hdead_beef;
        issue   = 1'b1;
      end
      @(posedge clk);
      #1;
      waited++;
    end
    issue = 1'b0;
    check_value({name, " latency"}, 32'd33, 32'(waited));
    check_value({name, " quotient"}, exp_q, wb_data);
    check_value({name, " flags"}, 32'(exp_flags), 32'(flags));
    check_value({name, " div_zero"}, 32'(b == 32'd0), 32'(div_zero));
    shadow_regs[d] = exp_q;
    shadow_flags   = exp_flags;
  endtask

  initial begin
    logic [stat_w-1:0] saved_flags;
    clk          = 1'b0;
    rst_n        = 1'b0;
    issue        = 1'b0;
    opcode       = '0;
    dst          = '0;
    src0         = '0;
    src1         = '0;
    use_imm      = 1'b0;
    imm          = '0;
    lfsr_state   = 32'd55;
    cycle_count  = 0;
    shadow_flags = '0;
    for (int r = 0; r < num_regs; r++) begin
      shadow_regs[r] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value("reset flags", 32'd0, 32'(flags));
    check_value("reset busy", 32'd0, 32'(busy));
    check_value("reset done", 32'd0, 32'(done));

    // Read cleared registers before loading and doubling each one
    for (int r = 0; r < num_regs; r++) begin
      run_uop("reset register", op_add, 3'(r), 3'(r), 3'(r), 1'b0, 32'd0);
    end
    for (int r = 0; r < num_regs; r++) begin
      run_uop("load", op_ldi, 3'(r), 3'd0, 3'd0, 1'b1, rand_bits(32));
    end
    for (int r = 0; r < num_regs; r++) begin
      run_uop("double", op_add, 3'(r), 3'(r), 3'(r), 1'b0, 32'd0);
    end

    // Random ALU traffic with about a quarter reloads
    for (int i = 0; i < 200; i++) begin
      if (rand_bits(2) == 32'd0) begin
        run_uop($sformatf("random load %0d", i), op_ldi, 3'(rand_bits(3)), 3'd0, 3'd0,
                1'b1, rand_bits(32));
      end else begin
        run_uop($sformatf("random op %0d", i), 4'(rand_bits(3)), 3'(rand_bits(3)),
                3'(rand_bits(3)), 3'(rand_bits(3)), 1'(rand_bits(1)), rand_bits(32));
      end
    end

    // Flag-only micro-ops followed by reads of their destinations
    run_uop("load r1", op_ldi, 3'd1, 3'd0, 3'd0, 1'b1, 32'h1234_5678);
    run_uop("load r2", op_ldi, 3'd2, 3'd0, 3'd0, 1'b1, 32'h1234_5678);
    run_uop("cmp equal", op_cmp, 3'd1, 3'd1, 3'd2, 1'b0, 32'd0);
    run_uop("cmp borrow", op_cmp, 3'd1, 3'd1, 3'd0, 1'b1, 32'h8000_0000);
    run_uop("test zero", op_test, 3'd2, 3'd2, 3'd0, 1'b1, 32'h0000_0081);
    run_uop("cmp dst kept", op_add, 3'd3, 3'd1, 3'd0, 1'b1, 32'd0);
    run_uop("test dst kept", op_add, 3'd3, 3'd2, 3'd0, 1'b1, 32'd0);
    run_uop("load zero", op_ldi, 3'd4, 3'd0, 3'd0, 1'b1, 32'd0);
    run_uop("zero minus one", op_sub, 3'd5, 3'd4, 3'd0, 1'b1, 32'd1);
    check_value("zero minus one flags", 32'h0b, 32'(flags));
    run_uop("clc", op_clc, 3'd0, 3'd0, 3'd0, 1'b0, 32'd0);
    check_value("clc flags", 32'h0a, 32'(flags));

    // Edge operands
    run_uop("load max", op_ldi, 3'd1, 3'd0, 3'd0, 1'b1, 32'h7fff_ffff);
    run_uop("max plus one", op_add, 3'd2, 3'd1, 3'd0, 1'b1, 32'd1);
    check_value("max plus one flags", 32'h1a, 32'(flags));
    run_uop("min minus one", op_sub, 3'd3, 3'd2, 3'd0, 1'b1, 32'd1);
    check_value("min minus one flags", 32'h12, 32'(flags));
    run_uop("load 0x10000", op_ldi, 3'd4, 3'd0, 3'd0, 1'b1, 32'h0001_0000);
    run_uop("mul wraps to zero", op_mul, 3'd5, 3'd4, 3'd0, 1'b1, 32'h0001_0000);
    check_value("mul wraps to zero flags", 32'h17, 32'(flags));
    run_uop("load ones", op_ldi, 3'd6, 3'd0, 3'd0, 1'b1, 32'hffff_ffff);
    run_uop("mul high half", op_mul, 3'd7, 3'd6, 3'd0, 1'b1, 32'd2);
    check_value("mul high half flags", 32'h19, 32'(flags));

    // Random divides back to back
    for (int i = 0; i < 30; i++) begin
      run_div($sformatf("random div %0d", i), 3'(rand_bits(3)), 3'(rand_bits(3)),
              3'(rand_bits(3)), 1'(rand_bits(1)), rand_bits(1 + int'(rand_bits(4))), 1'b0);
    end

    // Zero divisor with an issue attempt while busy
    run_uop("load dividend", op_ldi, 3'd1, 3'd0, 3'd0, 1'b1, 32'h0bad_f00d);
    run_uop("load r3", op_ldi, 3'd3, 3'd0, 3'd0, 1'b1, 32'h0000_1234);
    saved_flags = shadow_flags;
    run_div("div by zero", 3'd2, 3'd1, 3'd0, 1'b1, 32'd0, 1'b1);
    check_value("div by zero all ones", 32'hffff_ffff, wb_data);
    check_value("div by zero flags kept", 32'(saved_flags), 32'(flags));
    run_uop("ignored issue", op_add, 3'd4, 3'd3, 3'd0, 1'b1, 32'd0);
    run_div("div with poke", 3'd5, 3'd1, 3'd0, 1'b1, 32'd7, 1'b1);
    run_uop("ignored issue again", op_add, 3'd0, 3'd4, 3'd0, 1'b1, 32'd0);
    run_uop("quotient readback", op_add, 3'd0, 3'd5, 3'd0, 1'b1, 32'd0);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: sources.f
common/exec_pkg.sv
execute/alu.sv
execute/divider.sv
execute/execute.sv
verilog/uop_decode.sv
verilog/reg_file.sv
verilog/exec_core_top.sv
testbench/tb_exec_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_exec_core -o tb_exec_core &&
./obj_dir/tb_exec_core | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "Simulation result: pass" ||
{ echo "Simulation result: fail"; exit 1; }
